// File: memsys.f
source/memsys_pkg.sv
source/sram_cmd_arbiter.sv
source/sram_model.sv
source/sram_resp_router.sv
source/memsys_top.sv
tb/tb_clock_gen.sv
tb/memsys_tb.sv

// File: tb/memsys_tb.sv
`timescale 1ns/1ps

module memsys_tb
  import memsys_pkg::*;
();

  localparam real drive_dly      = 0.5;
  localparam int  clk_period     = 4;
  localparam int  n_rand         = 150;
  localparam int  n_directed     = 24;
  localparam int  cycles_per_cmd = 16;
  localparam int  timeout_cycles = (n_directed + 2 * n_rand) * cycles_per_cmd + 40;
  localparam int  wait_limit     = 200;

  logic clk;
  logic por_n;
  logic soft_rst_n;
  logic rst_n;

  logic              cmd_valid [2];
  logic              cmd_ready [2];
  logic [addr_w-1:0] cmd_addr [2];
  logic              cmd_wr_en [2];
  logic [data_w-1:0] cmd_wr_data [2];
  logic [strb_w-1:0] cmd_wr_strb [2];
  logic [tag_w-1:0]  cmd_tag [2];
  logic              rsp_valid [2];
  logic              rsp_ready [2];
  logic [data_w-1:0] rsp_data [2];
  logic [tag_w-1:0]  rsp_tag [2];

  // Reference memory and the responses each client still expects, as {tag, data}
  logic [data_w-1:0]       ref_mem [depth];
  logic                    ref_written [depth];
  logic [tag_w+data_w-1:0] exp_q0 [$];
  logic [tag_w+data_w-1:0] exp_q1 [$];
  logic                    exp_avail [2];
  logic [data_w-1:0]       exp_data [2];
  logic [tag_w-1:0]        exp_tag [2];
  logic                    favour_c0;

  logic [31:0] rng_state [3];
  logic        rand_done [2];
  int          mismatch_errors;
  int          other_errors;

  assign rst_n = por_n && soft_rst_n;

  tb_clock_gen i_clk_gen (
    .clk   (clk),
    .rst_n (por_n)
  );

  memsys_top i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .c0_cmd_valid   (cmd_valid[0]),
    .c0_cmd_ready   (cmd_ready[0]),
    .c0_cmd_addr    (cmd_addr[0]),
    .c0_cmd_wr_en   (cmd_wr_en[0]),
    .c0_cmd_wr_data (cmd_wr_data[0]),
    .c0_cmd_wr_strb (cmd_wr_strb[0]),
    .c0_cmd_tag     (cmd_tag[0]),
    .c0_rsp_valid   (rsp_valid[0]),
    .c0_rsp_ready   (rsp_ready[0]),
    .c0_rsp_data    (rsp_data[0]),
    .c0_rsp_tag     (rsp_tag[0]),
    .c1_cmd_valid   (cmd_valid[1]),
    .c1_cmd_ready   (cmd_ready[1]),
    .c1_cmd_addr    (cmd_addr[1]),
    .c1_cmd_wr_en   (cmd_wr_en[1]),
    .c1_cmd_wr_data (cmd_wr_data[1]),
    .c1_cmd_wr_strb (cmd_wr_strb[1]),
    .c1_cmd_tag     (cmd_tag[1]),
    .c1_rsp_valid   (rsp_valid[1]),
    .c1_rsp_ready   (rsp_ready[1]),
    .c1_rsp_data    (rsp_data[1]),
    .c1_rsp_tag     (rsp_tag[1])
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // A word never written since reset reads back as its own address
  function automatic logic [data_w-1:0] ref_word(input logic [addr_w-1:0] addr);
    return ref_written[addr] ? ref_mem[addr] : data_w'(addr);
  endfunction

  // Reference model follows every accepted command and every taken response
  always @(posedge clk) begin
    logic [data_w-1:0]       word;
    logic [tag_w+data_w-1:0] front0;
    logic [tag_w+data_w-1:0] front1;
    if (!rst_n) begin
      for (int a = 0; a < depth; a++)
        ref_written[a] = 1'b0;
      exp_q0.delete();
      exp_q1.delete();
      favour_c0 <= 1'b1;
    end else begin
      for (int c = 0; c < 2; c++) begin
        if (cmd_valid[c] && cmd_ready[c]) begin
          word = ref_word(cmd_addr[c]);
          if (cmd_wr_en[c]) begin
            for (int i = 0; i < strb_w; i++)
              if (cmd_wr_strb[c][i])
                word[i*8 +: 8] = cmd_wr_data[c][i*8 +: 8];
            ref_mem[cmd_addr[c]] = word;
            ref_written[cmd_addr[c]] = 1'b1;
          end else if (c == 0) begin
            exp_q0.push_back({cmd_tag[c], word});
          end else begin
            exp_q1.push_back({cmd_tag[c], word});
          end
          favour_c0 <= (c == 1);
        end
      end
      if (rsp_valid[0] && rsp_ready[0] && exp_q0.size() != 0)
        void'(exp_q0.pop_front());
      if (rsp_valid[1] && rsp_ready[1] && exp_q1.size() != 0)
        void'(exp_q1.pop_front());
    end
    front0 = (exp_q0.size() != 0) ? exp_q0[0] : '0;
    front1 = (exp_q1.size() != 0) ? exp_q1[0] : '0;
    exp_avail[0] <= exp_q0.size() != 0;
    exp_avail[1] <= exp_q1.size() != 0;
    {exp_tag[0], exp_data[0]} <= front0;
    {exp_tag[1], exp_data[1]} <= front1;
  end

  for (genvar c = 0; c < 2; c++) begin : g_rsp_check
    assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid[c] && !rsp_ready[c] |=>
        rsp_valid[c] && $stable(rsp_data[c]) && $stable(rsp_tag[c]))
      else begin
        other_errors++;
        $display("%0t: c%0d response dropped or changed before it was taken", $time, c);
      end
    assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid[c] && rsp_ready[c] |-> exp_avail[c])
      else begin
        other_errors++;
        $display("%0t: c%0d got a response with no read outstanding", $time, c);
      end
    assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid[c] && rsp_ready[c] && exp_avail[c] |-> rsp_data[c] == exp_data[c])
      else begin
        mismatch_errors++;
        $display("mismatch at %0t: c%0d_rsp_data expected %h got %h", $time, c,
                 $sampled(exp_data[c]), $sampled(rsp_data[c]));
      end
    assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid[c] && rsp_ready[c] && exp_avail[c] |-> rsp_tag[c] == exp_tag[c])
      else begin
        mismatch_errors++;
        $display("mismatch at %0t: c%0d_rsp_tag expected %h got %h", $time, c,
                 $sampled(exp_tag[c]), $sampled(rsp_tag[c]));
      end
  end

  // With both clients waiting, ready goes to the one that did not win last
  assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid[0] && cmd_valid[1] && (cmd_ready[0] || cmd_ready[1]) |->
      cmd_ready[0] == favour_c0 && cmd_ready[1] == !favour_c0)
    else begin
      mismatch_errors++;
      $display("mismatch at %0t: c0_cmd_ready expected %b got %b", $time,
               $sampled(favour_c0), $sampled(cmd_ready[0]));
    end

  assert property (@(posedge clk) disable iff (!rst_n) !(rsp_valid[0] && rsp_valid[1]))
    else begin
      other_errors++;
      $display("%0t: one response was offered to both clients", $time);
    end

  task automatic send_cmd(input int c, input logic wr, input logic [addr_w-1:0] addr,
                          input logic [data_w-1:0] wdata, input logic [strb_w-1:0] strb,
                          input logic [tag_w-1:0] tag);
    logic took;
    int   waited;
    took = 1'b0;
    waited = 0;
    cmd_valid[c] = 1'b1;
    cmd_wr_en[c] = wr;
    cmd_addr[c] = addr;
    cmd_wr_data[c] = wdata;
    cmd_wr_strb[c] = strb;
    cmd_tag[c] = tag;
    while (!took && waited < wait_limit) begin
      @(posedge clk);
      took = cmd_ready[c];
      waited++;
    end
    #drive_dly;
    cmd_valid[c] = 1'b0;
    assert (took) else begin
      other_errors++;
      $display("%0t: c%0d command was not accepted in %0d cycles", $time, c, wait_limit);
    end
  endtask

  task automatic check_idle_state();
    for (int c = 0; c < 2; c++) begin
      assert (!rsp_valid[c]) else begin
        mismatch_errors++;
        $display("mismatch at %0t: c%0d_rsp_valid expected 0 got %b", $time, c, rsp_valid[c]);
      end
      assert (cmd_ready[c]) else begin
        mismatch_errors++;
        $display("mismatch at %0t: c%0d_cmd_ready expected 1 got %b", $time, c, cmd_ready[c]);
      end
    end
  endtask

  // A lone read with rsp_ready high is taken two edges after its command
  task automatic check_read_latency(input logic [addr_w-1:0] addr);
    int   n;
    logic seen;
    n = 0;
    seen = 1'b0;
    send_cmd(0, 1'b0, addr, '0, '0, 4'h5);
    while (!seen && n < 10) begin
      seen = rsp_valid[0];
      @(posedge clk);
      #drive_dly;
      n++;
    end
    assert (n == 2) else begin
      mismatch_errors++;
      $display("mismatch at %0t: c0_rsp_valid delay expected 2 got %0d", $time, n);
    end
  endtask

  task automatic wait_for_drain();
    int n;
    n = 0;
    while ((exp_q0.size() != 0 || exp_q1.size() != 0) && n < wait_limit) begin
      @(posedge clk);
      #drive_dly;
      n++;
    end
    assert (exp_q0.size() == 0 && exp_q1.size() == 0) else begin
      other_errors++;
      $display("%0t: %0d read responses never arrived", $time, exp_q0.size() + exp_q1.size());
    end
  endtask

  task automatic issue_random_cmds(input int c);
    logic [31:0]      r1;
    logic [31:0]      r2;
    logic [tag_w-1:0] tag;
    tag = '0;
    for (int n = 0; n < n_rand; n++) begin
      rng_state[c] = xorshift(rng_state[c]);
      r1 = rng_state[c];
      rng_state[c] = xorshift(rng_state[c]);
      r2 = rng_state[c];
      if (r1[2:0] == 3'd0) begin
        @(posedge clk);
        #drive_dly;
      end
      // Half of the traffic goes to 16 words so reads and partial writes collide
      send_cmd(c, r1[3], r1[4] ? r1[15:8] : {4'h0, r1[11:8]}, r2, r1[19:16], tag);
      tag++;
    end
    rand_done[c] = 1'b1;
  endtask

  task automatic send_read_burst(input int c);
    for (int i = 0; i < 6; i++) begin
      send_cmd(c, 1'b0, (i == 5) ? 8'h30 : addr_w'(8'h10 + 2 * i + c), '0, '0, tag_w'(i));
    end
  endtask

  task automatic pulse_reset();
    soft_rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #drive_dly;
    soft_rst_n = 1'b1;
  endtask

  initial begin
    #(timeout_cycles * clk_period);
    other_errors++;
    $display("watchdog expired after %0d cycles with the run unfinished", timeout_cycles);
    $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    for (int c = 0; c < 2; c++) begin
      cmd_valid[c] = 1'b0;
      cmd_addr[c] = '0;
      cmd_wr_en[c] = 1'b0;
      cmd_wr_data[c] = '0;
      cmd_wr_strb[c] = '0;
      cmd_tag[c] = '0;
      rsp_ready[c] = 1'b1;
      rand_done[c] = 1'b0;
    end
    soft_rst_n = 1'b1;
    mismatch_errors = 0;
    other_errors = 0;
    rng_state[0] = xorshift(32'h5635bd8f);
    rng_state[1] = xorshift(rng_state[0]);
    rng_state[2] = xorshift(rng_state[1]);
    wait (por_n === 1'b1);

    check_idle_state();
    check_read_latency(8'h20);
    send_cmd(0, 1'b1, 8'h10, 32'hcafe_0010, 4'hf, 4'h0);
    send_cmd(1, 1'b1, 8'h11, 32'h1234_5678, 4'hf, 4'h0);
    send_cmd(0, 1'b0, 8'h10, '0, '0, 4'h3);
    send_cmd(1, 1'b0, 8'h11, '0, '0, 4'h9);
    // Partial writes to a fresh word, then a lane update on a written one
    send_cmd(0, 1'b1, 8'h30, 32'haabb_ccdd, 4'b0110, 4'h0);
    send_cmd(1, 1'b1, 8'h30, 32'h1122_3344, 4'b1000, 4'h0);
    send_cmd(0, 1'b0, 8'h30, '0, '0, 4'h7);
    send_cmd(0, 1'b1, 8'h10, 32'h0000_ff00, 4'b0010, 4'h0);
    send_cmd(1, 1'b0, 8'h10, '0, '0, 4'hc);
    wait_for_drain();

    fork
      issue_random_cmds(0);
      issue_random_cmds(1);
      begin
        while (!(rand_done[0] && rand_done[1])) begin
          @(posedge clk);
          #drive_dly;
          rng_state[2] = xorshift(rng_state[2]);
          rsp_ready[0] = rng_state[2][0];
          rsp_ready[1] = rng_state[2][1];
        end
        rsp_ready[0] = 1'b1;
        rsp_ready[1] = 1'b1;
      end
    join
    wait_for_drain();

    // Words written so far must read as unwritten after this reset
    pulse_reset();
    check_idle_state();
    fork
      send_read_burst(0);
      send_read_burst(1);
    join
    wait_for_drain();

    $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real period       = 4.0,
  parameter int  reset_cycles = 10
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2.0) clk = ~clk;
  end

  // Reset is released just after an edge, in step with the other inputs
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
  end

endmodule

// File: source/memsys_top.sv
`timescale 1ns/1ps

module memsys_top
  import memsys_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  input  logic              c0_cmd_valid,
  output logic              c0_cmd_ready,
  input  logic [addr_w-1:0] c0_cmd_addr,
  input  logic              c0_cmd_wr_en,
  input  logic [data_w-1:0] c0_cmd_wr_data,
  input  logic [strb_w-1:0] c0_cmd_wr_strb,
  input  logic [tag_w-1:0]  c0_cmd_tag,
  output logic              c0_rsp_valid,
  input  logic              c0_rsp_ready,
  output logic [data_w-1:0] c0_rsp_data,
  output logic [tag_w-1:0]  c0_rsp_tag,

  input  logic              c1_cmd_valid,
  output logic              c1_cmd_ready,
  input  logic [addr_w-1:0] c1_cmd_addr,
  input  logic              c1_cmd_wr_en,
  input  logic [data_w-1:0] c1_cmd_wr_data,
  input  logic [strb_w-1:0] c1_cmd_wr_strb,
  input  logic [tag_w-1:0]  c1_cmd_tag,
  output logic              c1_rsp_valid,
  input  logic              c1_rsp_ready,
  output logic [data_w-1:0] c1_rsp_data,
  output logic [tag_w-1:0]  c1_rsp_tag
);

  // Arbiter to memory
  logic              sram_cmd_valid;
  logic              sram_cmd_ready;
  logic [addr_w-1:0] sram_cmd_addr;
  logic [meta_w-1:0] sram_cmd_meta;
  logic              sram_cmd_wr_en;
  logic [data_w-1:0] sram_cmd_wr_data;
  logic [strb_w-1:0] sram_cmd_wr_strb;

  // Memory to router
  logic              sram_rd_resp_valid;
  logic              sram_rd_resp_ready;
  logic [data_w-1:0] sram_rd_resp_data;
  logic [meta_w-1:0] sram_rd_resp_meta;

  sram_cmd_arbiter i_arbiter (
    .clk              (clk),
    .rst_n            (rst_n),
    .c0_cmd_valid     (c0_cmd_valid),
    .c0_cmd_ready     (c0_cmd_ready),
    .c0_cmd_addr      (c0_cmd_addr),
    .c0_cmd_wr_en     (c0_cmd_wr_en),
    .c0_cmd_wr_data   (c0_cmd_wr_data),
    .c0_cmd_wr_strb   (c0_cmd_wr_strb),
    .c0_cmd_tag       (c0_cmd_tag),
    .c1_cmd_valid     (c1_cmd_valid),
    .c1_cmd_ready     (c1_cmd_ready),
    .c1_cmd_addr      (c1_cmd_addr),
    .c1_cmd_wr_en     (c1_cmd_wr_en),
    .c1_cmd_wr_data   (c1_cmd_wr_data),
    .c1_cmd_wr_strb   (c1_cmd_wr_strb),
    .c1_cmd_tag       (c1_cmd_tag),
    .sram_cmd_valid   (sram_cmd_valid),
    .sram_cmd_ready   (sram_cmd_ready),
    .sram_cmd_addr    (sram_cmd_addr),
    .sram_cmd_meta    (sram_cmd_meta),
    .sram_cmd_wr_en   (sram_cmd_wr_en),
    .sram_cmd_wr_data (sram_cmd_wr_data),
    .sram_cmd_wr_strb (sram_cmd_wr_strb)
  );

  sram_model i_sram (
    .clk                (clk),
    .rst_n              (rst_n),
    .sram_cmd_valid     (sram_cmd_valid),
    .sram_cmd_ready     (sram_cmd_ready),
    .sram_cmd_addr      (sram_cmd_addr),
    .sram_cmd_meta      (sram_cmd_meta),
    .sram_cmd_wr_en     (sram_cmd_wr_en),
    .sram_cmd_wr_data   (sram_cmd_wr_data),
    .sram_cmd_wr_strb   (sram_cmd_wr_strb),
    .sram_rd_resp_valid (sram_rd_resp_valid),
    .sram_rd_resp_ready (sram_rd_resp_ready),
    .sram_rd_resp_data  (sram_rd_resp_data),
    .sram_rd_resp_meta  (sram_rd_resp_meta)
  );

  sram_resp_router i_router (
    .clk                (clk),
    .rst_n              (rst_n),
    .sram_rd_resp_valid (sram_rd_resp_valid),
    .sram_rd_resp_ready (sram_rd_resp_ready),
    .sram_rd_resp_data  (sram_rd_resp_data),
    .sram_rd_resp_meta  (sram_rd_resp_meta),
    .c0_rsp_valid       (c0_rsp_valid),
    .c0_rsp_ready       (c0_rsp_ready),
    .c0_rsp_data        (c0_rsp_data),
    .c0_rsp_tag         (c0_rsp_tag),
    .c1_rsp_valid       (c1_rsp_valid),
    .c1_rsp_ready       (c1_rsp_ready),
    .c1_rsp_data        (c1_rsp_data),
    .c1_rsp_tag         (c1_rsp_tag)
  );

endmodule

// File: source/sram_resp_router.sv
`timescale 1ns/1ps

module sram_resp_router
  import memsys_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  input  logic              sram_rd_resp_valid,
  output logic              sram_rd_resp_ready,
  input  logic [data_w-1:0] sram_rd_resp_data,
  input  logic [meta_w-1:0] sram_rd_resp_meta,

  output logic              c0_rsp_valid,
  input  logic              c0_rsp_ready,
  output logic [data_w-1:0] c0_rsp_data,
  output logic [tag_w-1:0]  c0_rsp_tag,

  output logic              c1_rsp_valid,
  input  logic              c1_rsp_ready,
  output logic [data_w-1:0] c1_rsp_data,
  output logic [tag_w-1:0]  c1_rsp_tag
);

  logic                full;
  logic [data_w-1:0]   hold_data;
  logic [tag_w-1:0]    hold_tag;
  logic [client_w-1:0] hold_client;

  logic to_c1;
  logic taken;
  logic load;

  assign to_c1 = (hold_client == client_w'(1));

  // Only the addressed client's ready can free the entry
  assign taken = full && (to_c1 ? c1_rsp_ready : c0_rsp_ready);

  assign sram_rd_resp_ready = !full || taken;
  assign load               = sram_rd_resp_valid && sram_rd_resp_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (taken) begin
      full <= 1'b0;
    end
  end

  // Split metadata into return client and tag
  always_ff @(posedge clk) begin
    if (load) begin
      hold_data   <= sram_rd_resp_data;
      hold_tag    <= sram_rd_resp_meta[tag_w-1:0];
      hold_client <= sram_rd_resp_meta[meta_w-1 -: client_w];
    end
  end

  assign c0_rsp_valid = full && !to_c1;
  assign c1_rsp_valid = full && to_c1;

  // Payload goes to both ports, valid decides who owns it
  assign c0_rsp_data = hold_data;
  assign c0_rsp_tag  = hold_tag;
  assign c1_rsp_data = hold_data;
  assign c1_rsp_tag  = hold_tag;

endmodule

// File: source/sram_model.sv
`timescale 1ns/1ps

module sram_model
  import memsys_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  input  logic              sram_cmd_valid,
  output logic              sram_cmd_ready,
  input  logic [addr_w-1:0] sram_cmd_addr,
  input  logic [meta_w-1:0] sram_cmd_meta,
  input  logic              sram_cmd_wr_en,
  input  logic [data_w-1:0] sram_cmd_wr_data,
  input  logic [strb_w-1:0] sram_cmd_wr_strb,

  output logic              sram_rd_resp_valid,
  input  logic              sram_rd_resp_ready,
  output logic [data_w-1:0] sram_rd_resp_data,
  output logic [meta_w-1:0] sram_rd_resp_meta
);

  logic [data_w-1:0] mem [depth];

  // One flag per word, set by the first write after reset
  logic [depth-1:0] written;

  logic              cmd_fire;
  logic              rd_fire;
  logic              wr_fire;
  logic              resp_taken;
  logic [data_w-1:0] rd_word;

  // Accept while empty, or while the held response leaves this cycle
  assign sram_cmd_ready = !sram_rd_resp_valid || sram_rd_resp_ready;

  assign cmd_fire   = sram_cmd_valid && sram_cmd_ready;
  assign rd_fire    = cmd_fire && !sram_cmd_wr_en;
  assign wr_fire    = cmd_fire && sram_cmd_wr_en;
  assign resp_taken = sram_rd_resp_valid && sram_rd_resp_ready;

  // Never-written words read back as their own address
  assign rd_word = written[sram_cmd_addr] ? mem[sram_cmd_addr] : data_w'(sram_cmd_addr);

  // Byte-lane write. Lanes with a clear strobe keep their old value
  // or, on the first write after reset, take the address pattern
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int i = 0; i < strb_w; i++) begin
        if (sram_cmd_wr_strb[i]) begin
          mem[sram_cmd_addr][i*8 +: 8] <= sram_cmd_wr_data[i*8 +: 8];
        end else if (!written[sram_cmd_addr]) begin
          mem[sram_cmd_addr][i*8 +: 8] <= rd_word[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      written <= '0;
    end else if (wr_fire) begin
      written[sram_cmd_addr] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sram_rd_resp_valid <= 1'b0;
    end else if (rd_fire) begin
      sram_rd_resp_valid <= 1'b1;
    end else if (resp_taken) begin
      sram_rd_resp_valid <= 1'b0;
    end
  end

  // Response payload, loaded only on an accepted read
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      sram_rd_resp_data <= rd_word;
      sram_rd_resp_meta <= sram_cmd_meta;
    end
  end

endmodule

// File: source/sram_cmd_arbiter.sv
`timescale 1ns/1ps

module sram_cmd_arbiter
  import memsys_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  input  logic              c0_cmd_valid,
  output logic              c0_cmd_ready,
  input  logic [addr_w-1:0] c0_cmd_addr,
  input  logic              c0_cmd_wr_en,
  input  logic [data_w-1:0] c0_cmd_wr_data,
  input  logic [strb_w-1:0] c0_cmd_wr_strb,
  input  logic [tag_w-1:0]  c0_cmd_tag,

  input  logic              c1_cmd_valid,
  output logic              c1_cmd_ready,
  input  logic [addr_w-1:0] c1_cmd_addr,
  input  logic              c1_cmd_wr_en,
  input  logic [data_w-1:0] c1_cmd_wr_data,
  input  logic [strb_w-1:0] c1_cmd_wr_strb,
  input  logic [tag_w-1:0]  c1_cmd_tag,

  output logic              sram_cmd_valid,
  input  logic              sram_cmd_ready,
  output logic [addr_w-1:0] sram_cmd_addr,
  output logic [meta_w-1:0] sram_cmd_meta,
  output logic              sram_cmd_wr_en,
  output logic [data_w-1:0] sram_cmd_wr_data,
  output logic [strb_w-1:0] sram_cmd_wr_strb
);

  // Client that won the last accepted command
  logic last_winner;

  logic grant_c0;
  logic grant_c1;
  logic cmd_fire;
  logic [client_w-1:0] sel_client;
  logic [tag_w-1:0]    sel_tag;

  // A lone requester always wins, a tie goes to whoever did not win last time
  assign grant_c0 = c0_cmd_valid && (!c1_cmd_valid || last_winner);
  assign grant_c1 = c1_cmd_valid && (!c0_cmd_valid || !last_winner);

  assign sram_cmd_valid = c0_cmd_valid || c1_cmd_valid;

  // The losing client is held off, an idle port may see ready without effect
  assign c0_cmd_ready = sram_cmd_ready && !grant_c1;
  assign c1_cmd_ready = sram_cmd_ready && !grant_c0;

  assign cmd_fire = sram_cmd_valid && sram_cmd_ready;

  assign sel_client = client_w'(grant_c1);

  // Field mux onto the memory command
  always_comb begin
    if (grant_c1) begin
      sram_cmd_addr    = c1_cmd_addr;
      sram_cmd_wr_en   = c1_cmd_wr_en;
      sram_cmd_wr_data = c1_cmd_wr_data;
      sram_cmd_wr_strb = c1_cmd_wr_strb;
      sel_tag          = c1_cmd_tag;
    end else begin
      sram_cmd_addr    = c0_cmd_addr;
      sram_cmd_wr_en   = c0_cmd_wr_en;
      sram_cmd_wr_data = c0_cmd_wr_data;
      sram_cmd_wr_strb = c0_cmd_wr_strb;
      sel_tag          = c0_cmd_tag;
    end
  end

  // The router uses the upper bits to find the way back
  assign sram_cmd_meta = {sel_client, sel_tag};

  // Reset to client 1 as last winner so client 0 goes first
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_winner <= 1'b1;
    end else if (cmd_fire) begin
      last_winner <= grant_c1;
    end
  end

endmodule

// File: source/memsys_pkg.sv
package memsys_pkg;

  // Word address width, 256 words in the memory
  localparam int addr_w = 8;

  // Data word width
  localparam int data_w = 32;

  // One write strobe per byte lane
  localparam int strb_w = data_w / 8;

  // Tag chosen by the client and returned with its read data
  localparam int tag_w = 4;

  // Client number width, clients 0 and 1
  localparam int client_w = 1;

  // Metadata carried through the memory, client number above the tag
  localparam int meta_w = client_w + tag_w;

  // Number of words in the memory
  localparam int depth = 1 << addr_w;

endpackage
